// ==== hw/pong_macros.svh ====
`ifndef PONG_MACROS_SVH
`define PONG_MACROS_SVH

// Visible frame in pixels
`define FRAME_WIDTH            640
`define FRAME_HEIGHT           480

// Paddles
`define PLAYER_WIDTH           10
`define PLAYER_HEIGHT          80
`define PLAYER_1_X_POS         20
`define PLAYER_2_X_POS         610
`define PLAYER_SPEED           4      // Pixels per cycle
`define INITIAL_PLAYER_Y_POS   200

// Ball and serve
`define BALL_SIZE              10
`define BALL_CENTER_OFFSET     5
`define INITIAL_BALL_X_POS     315
`define INITIAL_BALL_Y_POS     235
`define SERVE_SPEED            4
`define COLLISION_OFFSET       4      // Wall band at top and bottom
`define EDGE_MARGIN            5

// Hit zones measured from the paddle top
`define CORNER_HIT_ZONE_SIZE   8
`define HIT_ZONE_1             0
`define HIT_ZONE_2             15
`define HIT_ZONE_3             30
`define HIT_ZONE_4             50
`define HIT_ZONE_5             65
`define HIT_ZONE_MAX           80

`define WIN_SCORE              7

`endif

// ==== hw/pong_pkg.sv ====
`include "pong_macros.svh"

package pong_pkg;

    typedef logic [11:0] coord_t;   // Pixel coordinate
    typedef logic [2:0]  score_t;
    typedef logic [2:0]  speed_t;   // Ball step per axis

    // Paddle travel limits
    localparam coord_t PADDLE_Y_MIN = 12'd1;
    localparam coord_t PADDLE_Y_MAX = coord_t'(`FRAME_HEIGHT - `PLAYER_HEIGHT - 1);

    typedef struct packed {
        logic up;
        logic down;
    } paddle_keys_t;

    typedef struct packed {
        logic move;
        logic check_hits;
        logic serve;
        logic restart;
    } ball_ctl_t;

    typedef struct packed {
        logic miss_left;
        logic miss_right;
        logic at_edge;
    } ball_event_t;

    typedef struct packed {
        logic point_1;
        logic point_2;
    } point_t;

    typedef enum logic [1:0] {WIN_NONE, WIN_P1, WIN_P2} winner_t;

    typedef enum logic [1:0] {ST_PAUSED, ST_PLAY, ST_MISS, ST_WON} game_state_t;

    typedef struct packed {
        coord_t ball_x;
        coord_t ball_y;
        coord_t paddle_1_y;
        coord_t paddle_2_y;
        score_t score_1;
        score_t score_2;
    } game_view_t;

endpackage

// ==== hw/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm (
    input  logic                  BALL_CLOCK,
    input  logic                  reset,
    input  logic                  start_pause,
    input  logic                  restart,
    input  pong_pkg::ball_event_t events,
    input  logic                  win,
    input  pong_pkg::winner_t     win_side,
    output pong_pkg::ball_ctl_t   ball_ctl,
    output pong_pkg::point_t      points,
    output logic                  paddle_en,
    output logic                  paddle_restart,
    output logic                  score_clear,
    output logic                  paused,
    output pong_pkg::winner_t     winner
);
    import pong_pkg::*;

    game_state_t state;
    logic        running;

    assign running        = (state == ST_PLAY) || (state == ST_MISS);
    assign paused         = !running;
    assign paddle_en      = running;
    assign paddle_restart = restart;  // Clears on the next edge
    assign score_clear    = restart;

    always_comb begin
        ball_ctl.move       = running;
        ball_ctl.check_hits = (state == ST_PLAY);  // No hits while the ball runs out
        // Serve is held back when a win arrives so the ball waits at the edge
        ball_ctl.serve      = (state == ST_MISS) && events.at_edge && !win;
        ball_ctl.restart    = restart;
        // A miss on one side scores for the other player
        points.point_1      = (state == ST_PLAY) && events.miss_right;
        points.point_2      = (state == ST_PLAY) && events.miss_left;
    end

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || restart) begin
            state  <= ST_PAUSED;
            winner <= WIN_NONE;
        end else if (win) begin
            state  <= ST_WON;
            winner <= win_side;
        end else begin
            case (state)
                ST_PAUSED: begin
                    if (start_pause) state <= ST_PLAY;
                end
                ST_PLAY: begin
                    if (events.miss_left || events.miss_right) begin
                        state <= ST_MISS;
                    end else if (start_pause) begin
                        state <= ST_PAUSED;
                    end
                end
                ST_MISS: begin
                    if (events.at_edge) state <= ST_PLAY;  // Serve issued this cycle
                end
                ST_WON: begin
                    if (start_pause) begin
                        state  <= ST_MISS;  // Finish the run-out and then serve
                        winner <= WIN_NONE;
                    end
                end
                default: state <= ST_PAUSED;
            endcase
        end
    end

endmodule

// ==== hw/score_counter.sv ====
`timescale 1ns/1ps
`include "pong_macros.svh"

module score_counter (
    input  logic              BALL_CLOCK,
    input  logic              reset,
    input  pong_pkg::point_t  points,
    input  logic              clear,
    output pong_pkg::score_t  score_1,
    output pong_pkg::score_t  score_2,
    output logic              win,
    output pong_pkg::winner_t win_side
);
    import pong_pkg::*;

    localparam score_t TOP_SCORE = score_t'(`WIN_SCORE);

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || clear) begin
            score_1  <= '0;
            score_2  <= '0;
            win      <= 1'b0;
            win_side <= WIN_NONE;
        end else begin
            win <= 1'b0;  // One-cycle pulse
            if (points.point_1) begin
                if (score_1 == TOP_SCORE) begin
                    // Eighth point wins and starts a fresh match
                    score_1  <= '0;
                    score_2  <= '0;
                    win      <= 1'b1;
                    win_side <= WIN_P1;
                end else begin
                    score_1 <= score_1 + 3'd1;
                end
            end else if (points.point_2) begin
                if (score_2 == TOP_SCORE) begin
                    score_1  <= '0;
                    score_2  <= '0;
                    win      <= 1'b1;
                    win_side <= WIN_P2;
                end else begin
                    score_2 <= score_2 + 3'd1;
                end
            end
        end
    end

endmodule

// ==== hw/paddle_mover.sv ====
`timescale 1ns/1ps
`include "pong_macros.svh"

module paddle_mover (
    input  logic                   BALL_CLOCK,
    input  logic                   reset,
    input  pong_pkg::paddle_keys_t keys,
    input  logic                   enable,
    input  logic                   restart,
    output pong_pkg::coord_t       y
);
    import pong_pkg::*;

    localparam coord_t STEP = coord_t'(`PLAYER_SPEED);
    localparam coord_t HOME = coord_t'(`INITIAL_PLAYER_Y_POS);

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || restart) begin
            y <= HOME;
        end else if (enable) begin
            if (keys.up) begin  // Up wins over down
                if (y < PADDLE_Y_MIN + STEP) begin
                    y <= PADDLE_Y_MIN;  // Clamp at the top
                end else begin
                    y <= y - STEP;
                end
            end else if (keys.down) begin
                if (y + STEP > PADDLE_Y_MAX) begin
                    y <= PADDLE_Y_MAX;  // Clamp at the bottom
                end else begin
                    y <= y + STEP;
                end
            end
        end
    end

endmodule

// ==== hw/ball_engine.sv ====
`timescale 1ns/1ps
`include "pong_macros.svh"

module ball_engine (
    input  logic                  BALL_CLOCK,
    input  logic                  reset,
    input  pong_pkg::ball_ctl_t   ctl,
    input  pong_pkg::coord_t      paddle_1_y,
    input  pong_pkg::coord_t      paddle_2_y,
    output pong_pkg::coord_t      ball_x,
    output pong_pkg::coord_t      ball_y,
    output pong_pkg::ball_event_t events
);
    import pong_pkg::*;

    localparam coord_t P1_FACE  = coord_t'(`PLAYER_1_X_POS + `PLAYER_WIDTH);
    localparam coord_t P2_FACE  = coord_t'(`PLAYER_2_X_POS);
    localparam coord_t BALL     = coord_t'(`BALL_SIZE);
    localparam coord_t X_START  = coord_t'(`INITIAL_BALL_X_POS);
    localparam coord_t Y_START  = coord_t'(`INITIAL_BALL_Y_POS);
    localparam coord_t WALL_TOP = coord_t'(`COLLISION_OFFSET);
    localparam coord_t WALL_BOT = coord_t'(`FRAME_HEIGHT - `COLLISION_OFFSET);
    localparam coord_t EDGE_L   = coord_t'(`EDGE_MARGIN);
    localparam coord_t EDGE_R   = coord_t'(`FRAME_WIDTH - `EDGE_MARGIN);
    localparam speed_t SERVE_DX = speed_t'(`SERVE_SPEED);

    // Result of checking the ball center against one paddle
    typedef struct packed {
        logic   hit;
        logic   keep;  // Vertical direction unchanged
        logic   up;
        speed_t dx;
        speed_t dy;
    } zone_t;

    function automatic zone_t classify(input coord_t c, input coord_t p);
        zone_t  z;
        coord_t d;
        d = c - p;
        // Fields are hit, keep, up, dx, dy
        if (c < p + coord_t'(`HIT_ZONE_1)) begin
            z = '{1'b1, 1'b0, 1'b1, 3'd1, 3'd3};  // Top corner
            if (c + coord_t'(`CORNER_HIT_ZONE_SIZE) < p) z.hit = 1'b0;
        end else if (d < coord_t'(`HIT_ZONE_2)) begin
            z = '{1'b1, 1'b0, 1'b1, 3'd2, 3'd2};
        end else if (d < coord_t'(`HIT_ZONE_3)) begin
            z = '{1'b1, 1'b0, 1'b1, 3'd3, 3'd1};
        end else if (d < coord_t'(`HIT_ZONE_4)) begin
            z = '{1'b1, 1'b1, 1'b0, 3'd4, 3'd0};  // Middle zone returns flat
        end else if (d < coord_t'(`HIT_ZONE_5)) begin
            z = '{1'b1, 1'b0, 1'b0, 3'd3, 3'd1};
        end else if (d < coord_t'(`HIT_ZONE_MAX)) begin
            z = '{1'b1, 1'b0, 1'b0, 3'd2, 3'd2};
        end else begin
            z = '{1'b1, 1'b0, 1'b0, 3'd1, 3'd3};  // Bottom corner
            if (d >= coord_t'(`HIT_ZONE_MAX + `CORNER_HIT_ZONE_SIZE)) z.hit = 1'b0;
        end
        return z;
    endfunction

    speed_t dx, dy;
    logic   dir_left, dir_up;
    coord_t center;
    logic   face_1, face_2;
    zone_t  zone_1, zone_2, zone;
    logic   hit;
    logic   nxt_left, nxt_up;
    speed_t nxt_dx, nxt_dy;

    assign center = ball_y + coord_t'(`BALL_CENTER_OFFSET);

    // Ball reaches a paddle face within one step
    assign face_1 = dir_left && (ball_x >= P1_FACE) && (ball_x <= P1_FACE + coord_t'(dx));
    assign face_2 = !dir_left && (ball_x + BALL <= P2_FACE)
                    && (ball_x + BALL + coord_t'(dx) >= P2_FACE);

    assign zone_1 = classify(center, paddle_1_y);
    assign zone_2 = classify(center, paddle_2_y);
    assign zone   = face_1 ? zone_1 : zone_2;
    assign hit    = ctl.check_hits && (face_1 || face_2) && zone.hit;

    always_comb begin
        events.miss_left  = ctl.check_hits && face_1 && !zone_1.hit;
        events.miss_right = ctl.check_hits && face_2 && !zone_2.hit;
        events.at_edge    = (ball_x <= EDGE_L) || (ball_x + BALL >= EDGE_R);
    end

    // Direction and speed for this step with a paddle hit overriding the wall
    always_comb begin
        nxt_left = dir_left;
        nxt_up   = dir_up;
        nxt_dx   = dx;
        nxt_dy   = dy;
        if (ball_y <= WALL_TOP) begin
            nxt_up = 1'b0;
        end else if (ball_y + BALL >= WALL_BOT) begin
            nxt_up = 1'b1;
        end
        if (hit) begin
            nxt_left = !dir_left;
            nxt_dx   = zone.dx;
            nxt_dy   = zone.dy;
            if (!zone.keep) nxt_up = zone.up;
        end
    end

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || ctl.restart) begin
            ball_x   <= X_START;
            ball_y   <= Y_START;
            dx       <= SERVE_DX;
            dy       <= 3'd0;
            dir_left <= 1'b0;  // Always serve right after restart
            dir_up   <= 1'b0;
        end else if (ctl.serve) begin
            ball_x <= X_START;
            ball_y <= Y_START;
            dx     <= SERVE_DX;
            dy     <= 3'd0;
        end else if (ctl.move) begin
            ball_x   <= nxt_left ? ball_x - coord_t'(nxt_dx) : ball_x + coord_t'(nxt_dx);
            ball_y   <= nxt_up ? ball_y - coord_t'(nxt_dy) : ball_y + coord_t'(nxt_dy);
            dx       <= nxt_dx;
            dy       <= nxt_dy;
            dir_left <= nxt_left;
            dir_up   <= nxt_up;
        end
    end

endmodule

// ==== hw/pong_top.sv ====
`timescale 1ns/1ps

module pong_top (
    input  logic                   BALL_CLOCK,
    input  logic                   reset,
    input  logic                   start_pause,
    input  logic                   restart,
    input  pong_pkg::paddle_keys_t keys_1,
    input  pong_pkg::paddle_keys_t keys_2,
    output pong_pkg::game_view_t   view,
    output pong_pkg::winner_t      winner,
    output logic                   paused
);
    import pong_pkg::*;

    ball_ctl_t   ball_ctl;
    ball_event_t events;
    point_t      points;
    logic        paddle_en, paddle_restart, score_clear;
    logic        win;
    winner_t     win_side;
    coord_t      ball_x, ball_y, paddle_1_y, paddle_2_y;
    score_t      score_1, score_2;

    // All fields come straight from registers
    assign view = '{ball_x, ball_y, paddle_1_y, paddle_2_y, score_1, score_2};

    game_fsm fsm (
        .BALL_CLOCK(BALL_CLOCK), .reset(reset),
        .start_pause(start_pause), .restart(restart),
        .events(events), .win(win), .win_side(win_side),
        .ball_ctl(ball_ctl), .points(points),
        .paddle_en(paddle_en), .paddle_restart(paddle_restart),
        .score_clear(score_clear), .paused(paused), .winner(winner)
    );

    score_counter scores (
        .BALL_CLOCK(BALL_CLOCK), .reset(reset),
        .points(points), .clear(score_clear),
        .score_1(score_1), .score_2(score_2),
        .win(win), .win_side(win_side)
    );

    paddle_mover paddle_1 (
        .BALL_CLOCK(BALL_CLOCK), .reset(reset), .keys(keys_1),
        .enable(paddle_en), .restart(paddle_restart), .y(paddle_1_y)
    );

    paddle_mover paddle_2 (
        .BALL_CLOCK(BALL_CLOCK), .reset(reset), .keys(keys_2),
        .enable(paddle_en), .restart(paddle_restart), .y(paddle_2_y)
    );

    ball_engine ball (
        .BALL_CLOCK(BALL_CLOCK), .reset(reset), .ctl(ball_ctl),
        .paddle_1_y(paddle_1_y), .paddle_2_y(paddle_2_y),
        .ball_x(ball_x), .ball_y(ball_y), .events(events)
    );

endmodule

// ==== test/pong_chk.sv ====
`timescale 1ns/1ps
`include "pong_macros.svh"

module pong_chk (
    input logic                 BALL_CLOCK,
    input logic                 reset,
    input pong_pkg::game_view_t view,
    input pong_pkg::winner_t    winner,
    input logic                 paused
);
    import pong_pkg::*;

    localparam coord_t Y_MIN = coord_t'(1);
    localparam coord_t Y_MAX = coord_t'(`FRAME_HEIGHT - `PLAYER_HEIGHT - 1);

    int failures = 0;  // Read by the testbench at the end

    paddle_range: assert property (@(posedge BALL_CLOCK) disable iff (reset)
        view.paddle_1_y >= Y_MIN && view.paddle_1_y <= Y_MAX
        && view.paddle_2_y >= Y_MIN && view.paddle_2_y <= Y_MAX)
        else begin
            failures++;
            $error("paddle outside its travel range");
        end

    // A winner is only shown on the paused win screen
    winner_paused: assert property (@(posedge BALL_CLOCK) disable iff (reset)
        winner != WIN_NONE |-> paused)
        else begin
            failures++;
            $error("winner set while the game runs");
        end

    // Scores climb one point at a time or clear
    score_step: assert property (@(posedge BALL_CLOCK) disable iff (reset)
        (view.score_1 == $past(view.score_1) || view.score_1 == $past(view.score_1) + 3'd1
         || view.score_1 == 3'd0)
        && (view.score_2 == $past(view.score_2) || view.score_2 == $past(view.score_2) + 3'd1
         || view.score_2 == 3'd0))
        else begin
            failures++;
            $error("score changed by more than one point");
        end

endmodule

// ==== test/pong_tb.sv ====
`timescale 1ns/1ps
`include "pong_macros.svh"

module pong_tb;
    import pong_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_Y = `FRAME_HEIGHT - `PLAYER_HEIGHT - 1;
    // Cycle budget per test after the reset cycles
    localparam int RUN_CYCLES = 16 + 15 + 185 + 100 + 310 + 910 + 215;
    localparam coord_t X0 = coord_t'(`INITIAL_BALL_X_POS);
    localparam coord_t Y0 = coord_t'(`INITIAL_BALL_Y_POS);
    localparam coord_t P0 = coord_t'(`INITIAL_PLAYER_Y_POS);

    logic         BALL_CLOCK;
    logic         reset;
    logic         start_pause;
    logic         restart;
    paddle_keys_t keys_1;
    paddle_keys_t keys_2;
    game_view_t   view;
    winner_t      winner;
    logic         paused;

    int     value_errors = 0;
    int     other_failures = 0;
    integer seed = 94;

    pong_top dut0 (
        .BALL_CLOCK(BALL_CLOCK), .reset(reset),
        .start_pause(start_pause), .restart(restart),
        .keys_1(keys_1), .keys_2(keys_2),
        .view(view), .winner(winner), .paused(paused)
    );

    bind pong_top pong_chk chk0 (
        .BALL_CLOCK(BALL_CLOCK), .reset(reset),
        .view(view), .winner(winner), .paused(paused)
    );

    initial begin
        BALL_CLOCK = 1'b0;
        forever #(CLK_PERIOD / 2) BALL_CLOCK = ~BALL_CLOCK;
    end

    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    // Past the edge and the input drive point
    task automatic step(input int n = 1);
        repeat (n) @(posedge BALL_CLOCK);
        #1;
    endtask

    task automatic mismatch(input string what, input int got, input int want);
        value_errors++;
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, want);
    endtask

    task automatic fail_wait(input string what);
        other_failures++;
        $display("At %0t the game never showed %s", $time, what);
    endtask

    task automatic pulse_start();
        start_pause = 1'b1;
        step();
        start_pause = 1'b0;
    endtask

    task automatic pulse_restart();
        restart = 1'b1;
        step();
        restart = 1'b0;
    endtask

    // Every output at its value after reset
    task automatic check_home();
        if (view.ball_x != X0) mismatch("ball_x", int'(view.ball_x), int'(X0));
        if (view.ball_y != Y0) mismatch("ball_y", int'(view.ball_y), int'(Y0));
        if (view.paddle_1_y != P0) mismatch("paddle_1_y", int'(view.paddle_1_y), int'(P0));
        if (view.paddle_2_y != P0) mismatch("paddle_2_y", int'(view.paddle_2_y), int'(P0));
        if (view.score_1 != 3'd0) mismatch("score_1", int'(view.score_1), 0);
        if (view.score_2 != 3'd0) mismatch("score_2", int'(view.score_2), 0);
        if (paused != 1'b1) mismatch("paused", int'(paused), 1);
        if (winner != WIN_NONE) mismatch("winner", int'(winner), int'(WIN_NONE));
    endtask

    // Holds one key of paddle 1 while want tracks the clamped position
    task automatic drive_paddle_1(input logic up, input int cycles, inout int want);
        keys_1.up   = up;
        keys_1.down = !up;
        for (int i = 0; i < cycles; i++) begin
            step();
            if (up) want = (want - `PLAYER_SPEED < 1) ? 1 : want - `PLAYER_SPEED;
            else want = (want + `PLAYER_SPEED > MAX_Y) ? MAX_Y : want + `PLAYER_SPEED;
            if (int'(view.paddle_1_y) != want)
                mismatch("paddle_1_y", int'(view.paddle_1_y), want);
        end
        keys_1 = '0;
    endtask

    task automatic test_reset_state();
        check_home();
        keys_1.down = 1'b1;  // Keys do nothing while paused
        keys_2.up   = 1'b1;
        step(10);
        check_home();
        keys_1 = '0;
        keys_2 = '0;
    endtask

    task automatic test_paddle_moves();
        int         n;
        int         want;
        game_view_t frozen;
        n = ($random(seed) & 15) + 1;
        want = `INITIAL_PLAYER_Y_POS;
        pulse_start();
        if (paused != 1'b0) mismatch("paused", int'(paused), 0);
        drive_paddle_1(1'b1, n, want);
        step(2);
        if (int'(view.paddle_1_y) != want) mismatch("idle paddle_1_y", int'(view.paddle_1_y), want);
        drive_paddle_1(1'b1, 50, want);
        if (view.paddle_1_y != 12'd1) mismatch("top clamp", int'(view.paddle_1_y), 1);
        drive_paddle_1(1'b0, 101, want);
        if (int'(view.paddle_1_y) != MAX_Y) mismatch("bottom clamp", int'(view.paddle_1_y), MAX_Y);
        pulse_start();
        if (paused != 1'b1) mismatch("paused", int'(paused), 1);
        frozen = view;
        keys_1.up   = 1'b1;
        keys_2.down = 1'b1;
        step(8);
        if (view != frozen) begin
            value_errors++;
            $display("ERR %0t: view changed while paused", $time);
        end
        keys_1 = '0;
        keys_2 = '0;
    endtask

    task automatic test_ball_bounce();
        int want_x;
        int dir;
        pulse_restart();
        check_home();
        pulse_start();
        want_x = `INITIAL_BALL_X_POS;
        dir = `SERVE_SPEED;
        for (int i = 0; i < 90; i++) begin
            // Center 240 lies in the middle zone of paddle 2
            if (dir > 0 && want_x + `BALL_SIZE + dir >= `PLAYER_2_X_POS) dir = -dir;
            step();
            want_x += dir;
            if (int'(view.ball_x) != want_x) mismatch("ball_x", int'(view.ball_x), want_x);
            if (view.ball_y != Y0) mismatch("ball_y", int'(view.ball_y), int'(Y0));
        end
    endtask

    task automatic test_miss_scores();
        pulse_restart();
        keys_2.up = 1'b1;  // Paddle 2 parks at the top
        pulse_start();
        for (int i = 0; i < 200 && view.score_1 != 3'd1; i++) step();
        if (view.score_1 != 3'd1) fail_wait("score_1 reaching 1");
        if (view.score_2 != 3'd0) mismatch("score_2", int'(view.score_2), 0);
        if (view.paddle_2_y != 12'd1) mismatch("paddle_2_y", int'(view.paddle_2_y), 1);
        for (int i = 0; i < 100 && !(view.ball_x == X0 && view.ball_y == Y0); i++) step();
        if (view.ball_x != X0 || view.ball_y != Y0) fail_wait("a serve from the start position");
    endtask

    task automatic test_win();
        logic saw_seven;
        saw_seven = 1'b0;
        for (int i = 0; i < 900 && winner != WIN_P1; i++) begin
            step();
            if (view.score_1 == 3'd7) saw_seven = 1'b1;
        end
        if (winner != WIN_P1) fail_wait("player 1 winning");
        if (!saw_seven) fail_wait("score_1 at 7 before the win");
        if (paused != 1'b1) mismatch("paused after win", int'(paused), 1);
        if (view.score_1 != 3'd0) mismatch("score_1 after win", int'(view.score_1), 0);
        if (view.score_2 != 3'd0) mismatch("score_2 after win", int'(view.score_2), 0);
        pulse_start();
        if (winner != WIN_NONE) mismatch("winner", int'(winner), int'(WIN_NONE));
        if (paused != 1'b0) mismatch("paused", int'(paused), 0);
    endtask

    task automatic test_restart();
        keys_1.down = 1'b1;
        for (int i = 0; i < 200 && view.score_1 == 3'd0; i++) step();
        if (view.score_1 == 3'd0) fail_wait("a point before the restart");
        keys_1 = '0;
        keys_2 = '0;
        pulse_restart();
        check_home();
        step(5);
        check_home();
    endtask

    initial begin
        reset       = 1'b1;
        start_pause = 1'b0;
        restart     = 1'b0;
        keys_1      = '0;
        keys_2      = '0;
        repeat (16) @(posedge BALL_CLOCK);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_paddle_moves();
        test_ball_bounce();
        test_miss_scores();
        test_win();
        test_restart();
        $display("Value errors: %0d, other failures: %0d, assertion failures: %0d",
                 value_errors, other_failures, dut0.chk0.failures);
        if (value_errors == 0 && other_failures == 0 && dut0.chk0.failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/pong_pkg.sv
hw/game_fsm.sv
hw/score_counter.sv
hw/paddle_mover.sv
hw/ball_engine.sv
hw/pong_top.sv
test/pong_chk.sv
test/pong_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the Pong testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/1ps --top-module pong_tb \
    -f tb.f -o pong_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/pong_sim > sim.log 2>&1 || echo "RESULT: FAIL (simulator exit status)" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
